/* rtl/eth_pkg.sv */
// Ethernet-level definitions shared by the IPv4 transmit path.
// Holds the MAC address type, the Ethernet header layout and the
// payload beat that travels on the 64-bit valid/ready streams.
// Import with a wildcard import in the module header.

package eth_pkg;

  // Payload stream width in bits
  localparam int DATA_W = 64;

  typedef logic [47:0] mac_addr_t;

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

  // Ethernet II header, 112 bits, destination first on the wire
  typedef struct packed {
    mac_addr_t   dest_mac;
    mac_addr_t   src_mac;
    logic [15:0] ethertype;
  } eth_hdr_t;

  // One payload transfer, tlast only
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } axis_beat_t;

endpackage

/* rtl/ip_pkg.sv */
// IPv4 definitions for the transmit path.
// Holds the 160-bit header layout, its word view for the checksum,
// the transmit request and the combined outgoing Ethernet/IPv4 header.

package ip_pkg;

  import eth_pkg::*;

  typedef logic [31:0] ip_addr_t;

  localparam logic [3:0]  IPV4_VERSION  = 4'd4;
  localparam logic [3:0]  IPV4_IHL      = 4'd5;
  localparam logic [2:0]  IPV4_FLAGS_DF = 3'b010;
  // RoCE packets carry a 4-byte ICRC after the payload
  localparam logic [15:0] ROCE_LEN_ADJ  = 16'd4;

  // All ones marks an empty cache entry
  localparam ip_addr_t CACHE_RESET_IP = '1;

  typedef struct packed {
    logic [3:0]  version;
    logic [3:0]  ihl;
    logic [5:0]  dscp;
    logic [1:0]  ecn;
    logic [15:0] total_length;
    logic [15:0] identification;
    logic [2:0]  flags;
    logic [12:0] frag_offset;
    logic [7:0]  ttl;
    logic [7:0]  protocol;
    logic [15:0] checksum;
    ip_addr_t    source_ip;
    ip_addr_t    dest_ip;
  } ipv4_fields_t;

  // Same 160 bits seen as ten header words for the checksum
  typedef union packed {
    ipv4_fields_t     fields;
    logic [9:0][15:0] words;
  } ipv4_hdr_u;

  typedef struct packed {
    logic [5:0]  dscp;
    logic [1:0]  ecn;
    logic [15:0] length;
    logic [7:0]  ttl;
    logic [7:0]  protocol;
    ip_addr_t    source_ip;
    ip_addr_t    dest_ip;
    logic        roce;
  } ip_tx_req_t;

  typedef struct packed {
    eth_hdr_t     eth;
    ipv4_fields_t ip;
    logic         roce;
  } eth_ip_hdr_t;

endpackage

/* rtl/arp_cache.sv */
// Single-entry ARP cache for the IPv4 transmit block.
// Remembers the last resolved IP address and its MAC; hit is a plain
// compare against the lookup address. fill writes both together.

`timescale 1ns/1ps

module arp_cache
  import eth_pkg::*;
  import ip_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  ip_addr_t  lookup_ip,
  input  logic      fill,
  input  mac_addr_t fill_mac,
  output logic      hit,
  output mac_addr_t mac
);

  ip_addr_t  ip_reg;
  mac_addr_t mac_reg;

  // Broadcast address as the empty marker
  always_ff @(posedge clk) begin
    if (rst) begin
      ip_reg <= CACHE_RESET_IP;
    end else if (fill) begin
      ip_reg <= lookup_ip;
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      mac_reg <= fill_mac;
    end
  end

  assign hit = (lookup_ip == ip_reg);
  assign mac = mac_reg;

endmodule

/* rtl/ip_hdr_assembler.sv */
// Builds the outgoing Ethernet/IPv4 header.
// load captures the header fields and their raw 20-bit word sum,
// fold reduces the sum in a second cycle when CHECKSUM_PIPELINED is 1,
// emit latches the destination MAC and raises out_hdr_valid until taken.

`timescale 1ns/1ps

module ip_hdr_assembler
  import eth_pkg::*;
  import ip_pkg::*;
#(
  parameter int CHECKSUM_PIPELINED = 0
) (
  input  logic        clk,
  input  logic        rst,
  input  ip_tx_req_t  req,
  input  mac_addr_t   local_mac,
  input  logic        load,
  input  logic        fold,
  input  logic        emit,
  input  mac_addr_t   dest_mac,
  output eth_ip_hdr_t out_hdr,
  output logic        out_hdr_valid,
  input  logic        out_hdr_ready,
  output logic        busy
);

  ipv4_hdr_u    hdr_new;
  logic [19:0]  raw_sum;
  logic [19:0]  sum_reg;
  logic [15:0]  csum_reg;
  ipv4_fields_t fields_reg;
  logic         roce_reg;
  mac_addr_t    src_mac_reg;
  mac_addr_t    dest_mac_reg;
  logic         valid_reg;

  // Ones'-complement fold of the 20-bit sum, two carry passes
  function automatic logic [15:0] fold_sum(input logic [19:0] s);
    logic [16:0] t;
    t = {1'b0, s[15:0]} + {13'd0, s[19:16]};
    return t[15:0] + {15'd0, t[16]};
  endfunction

  always_comb begin
    hdr_new.fields                = '0;
    hdr_new.fields.version        = IPV4_VERSION;
    hdr_new.fields.ihl            = IPV4_IHL;
    hdr_new.fields.dscp           = req.dscp;
    hdr_new.fields.ecn            = req.ecn;
    hdr_new.fields.total_length   = req.roce ? req.length + ROCE_LEN_ADJ : req.length;
    hdr_new.fields.flags          = IPV4_FLAGS_DF;
    hdr_new.fields.ttl            = req.ttl;
    hdr_new.fields.protocol       = req.protocol;
    hdr_new.fields.source_ip      = req.source_ip;
    hdr_new.fields.dest_ip        = req.dest_ip;
    // Checksum word is still zero here
    raw_sum = '0;
    for (int i = 0; i < 10; i++) begin
      raw_sum = raw_sum + {4'd0, hdr_new.words[i]};
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      sum_reg     <= raw_sum;
      fields_reg  <= hdr_new.fields;
      roce_reg    <= req.roce;
      src_mac_reg <= local_mac;
    end
    if (CHECKSUM_PIPELINED == 0) begin
      if (load) begin
        csum_reg <= ~fold_sum(raw_sum);
      end
    end else if (fold) begin
      csum_reg <= ~fold_sum(sum_reg);
    end
    if (emit) begin
      dest_mac_reg <= dest_mac;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_reg <= 1'b0;
    end else if (emit) begin
      valid_reg <= 1'b1;
    end else if (out_hdr_ready) begin
      valid_reg <= 1'b0;
    end
  end

  always_comb begin
    out_hdr.eth.dest_mac  = dest_mac_reg;
    out_hdr.eth.src_mac   = src_mac_reg;
    out_hdr.eth.ethertype = ETHERTYPE_IPV4;
    out_hdr.ip            = fields_reg;
    out_hdr.ip.checksum   = csum_reg;
    out_hdr.roce          = roce_reg;
  end

  assign out_hdr_valid = valid_reg;
  assign busy          = valid_reg;

endmodule

/* rtl/payload_gate.sv */
// Payload gate for one packet at a time.
// start opens the gate and samples drop; the gate closes on the
// accepted last beat and pulses done. Dropped packets are accepted
// at full rate and never reach the output.

`timescale 1ns/1ps

module payload_gate
  import eth_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic       drop,
  input  axis_beat_t in_beat,
  input  logic       in_valid,
  output logic       in_ready,
  output axis_beat_t out_beat,
  output logic       out_valid,
  input  logic       out_ready,
  output logic       done
);

  logic open_reg;
  logic drop_reg;

  assign in_ready  = open_reg && (drop_reg || out_ready);
  assign out_valid = open_reg && !drop_reg && in_valid;
  assign out_beat  = in_beat;
  assign done      = in_valid && in_ready && in_beat.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      open_reg <= 1'b0;
      drop_reg <= 1'b0;
    end else if (start) begin
      open_reg <= 1'b1;
      drop_reg <= drop;
    end else if (done) begin
      open_reg <= 1'b0;
      drop_reg <= 1'b0;
    end
  end

endmodule

/* rtl/ip_tx_ctrl.sv */
// Packet-level sequencer for the IPv4 transmit block.
// Looks up the destination in the ARP cache, queries the ARP responder
// on a miss, hands the header to the assembler and waits for the
// payload's last beat before taking the next request.

`timescale 1ns/1ps

module ip_tx_ctrl
  import eth_pkg::*;
  import ip_pkg::*;
#(
  parameter int CHECKSUM_PIPELINED = 0
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       req_valid,
  input  ip_tx_req_t req,
  output logic       req_ready,
  output logic       arp_req_valid,
  input  logic       arp_req_ready,
  output ip_addr_t   arp_req_ip,
  input  logic       arp_resp_valid,
  output logic       arp_resp_ready,
  input  logic       arp_resp_error,
  input  mac_addr_t  arp_resp_mac,
  input  logic       cache_hit,
  input  mac_addr_t  cache_mac,
  output ip_addr_t   cache_lookup_ip,
  output logic       cache_fill,
  output logic       hdr_load,
  output logic       hdr_fold,
  output logic       hdr_emit,
  output mac_addr_t  hdr_dest_mac,
  input  logic       hdr_busy,
  output logic       pkt_start,
  output logic       pkt_drop,
  input  logic       pkt_done
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_CSUM,
    S_ARP,
    S_WAIT
  } state_t;

  state_t state, state_next;
  logic   req_ready_next;
  logic   arp_req_valid_next;
  logic   arp_resp_ready_next;

  // The request is held until req_ready, so its destination is stable
  assign cache_lookup_ip = req.dest_ip;
  assign arp_req_ip      = req.dest_ip;

  always_comb begin
    state_next          = state;
    req_ready_next      = 1'b0;
    arp_req_valid_next  = 1'b0;
    arp_resp_ready_next = 1'b0;
    cache_fill          = 1'b0;
    hdr_load            = 1'b0;
    hdr_fold            = 1'b0;
    hdr_emit            = 1'b0;
    hdr_dest_mac        = cache_mac;
    pkt_start           = 1'b0;
    pkt_drop            = 1'b0;

    case (state)
      S_IDLE: begin
        // Previous header must be gone before its registers are reused
        if (req_valid && !hdr_busy) begin
          hdr_load = 1'b1;
          if (!cache_hit) begin
            arp_req_valid_next  = 1'b1;
            arp_resp_ready_next = 1'b1;
            state_next          = S_ARP;
          end else if (CHECKSUM_PIPELINED != 0) begin
            state_next = S_CSUM;
          end else begin
            hdr_emit       = 1'b1;
            req_ready_next = 1'b1;
            pkt_start      = 1'b1;
            state_next     = S_WAIT;
          end
        end
      end
      S_CSUM: begin
        hdr_fold       = 1'b1;
        hdr_emit       = 1'b1;
        req_ready_next = 1'b1;
        pkt_start      = 1'b1;
        state_next     = S_WAIT;
      end
      S_ARP: begin
        // Fold runs while the responder is busy, result is ready either way
        hdr_fold            = 1'b1;
        arp_req_valid_next  = arp_req_valid && !arp_req_ready;
        arp_resp_ready_next = 1'b1;
        if (arp_resp_valid && arp_resp_ready) begin
          arp_resp_ready_next = 1'b0;
          req_ready_next      = 1'b1;
          pkt_start           = 1'b1;
          state_next          = S_WAIT;
          if (arp_resp_error) begin
            // No MAC, so the payload is swallowed
            pkt_drop = 1'b1;
          end else begin
            cache_fill   = 1'b1;
            hdr_emit     = 1'b1;
            hdr_dest_mac = arp_resp_mac;
          end
        end
      end
      S_WAIT: begin
        if (pkt_done) begin
          state_next = S_IDLE;
        end
      end
      default: state_next = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= S_IDLE;
      req_ready      <= 1'b0;
      arp_req_valid  <= 1'b0;
      arp_resp_ready <= 1'b0;
    end else begin
      state          <= state_next;
      req_ready      <= req_ready_next;
      arp_req_valid  <= arp_req_valid_next;
      arp_resp_ready <= arp_resp_ready_next;
    end
  end

endmodule

/* rtl/ip_tx_top.sv */
// IPv4 transmit block, top level.
// Takes an IP header request plus its payload stream, resolves the
// destination MAC through a one-entry ARP cache and emits an
// Ethernet/IPv4 header followed by the payload beats.
// CHECKSUM_PIPELINED adds one cycle for the checksum fold.

`timescale 1ns/1ps

module ip_tx_top
  import eth_pkg::*;
  import ip_pkg::*;
#(
  parameter int CHECKSUM_PIPELINED = 0
) (
  input  logic        clk,
  input  logic        rst,
  input  ip_tx_req_t  req,
  input  logic        req_valid,
  output logic        req_ready,
  input  axis_beat_t  in_beat,
  input  logic        in_valid,
  output logic        in_ready,
  output logic        arp_req_valid,
  input  logic        arp_req_ready,
  output ip_addr_t    arp_req_ip,
  input  logic        arp_resp_valid,
  output logic        arp_resp_ready,
  input  logic        arp_resp_error,
  input  mac_addr_t   arp_resp_mac,
  output eth_ip_hdr_t out_hdr,
  output logic        out_hdr_valid,
  input  logic        out_hdr_ready,
  output axis_beat_t  out_beat,
  output logic        out_valid,
  input  logic        out_ready,
  input  mac_addr_t   local_mac
);

  ip_addr_t  cache_lookup_ip;
  logic      cache_fill;
  logic      cache_hit;
  mac_addr_t cache_mac;
  logic      hdr_load;
  logic      hdr_fold;
  logic      hdr_emit;
  mac_addr_t hdr_dest_mac;
  logic      hdr_busy;
  logic      pkt_start;
  logic      pkt_drop;
  logic      pkt_done;

  ip_tx_ctrl #(
    .CHECKSUM_PIPELINED(CHECKSUM_PIPELINED)
  ) u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .req_valid      (req_valid),
    .req            (req),
    .req_ready      (req_ready),
    .arp_req_valid  (arp_req_valid),
    .arp_req_ready  (arp_req_ready),
    .arp_req_ip     (arp_req_ip),
    .arp_resp_valid (arp_resp_valid),
    .arp_resp_ready (arp_resp_ready),
    .arp_resp_error (arp_resp_error),
    .arp_resp_mac   (arp_resp_mac),
    .cache_hit      (cache_hit),
    .cache_mac      (cache_mac),
    .cache_lookup_ip(cache_lookup_ip),
    .cache_fill     (cache_fill),
    .hdr_load       (hdr_load),
    .hdr_fold       (hdr_fold),
    .hdr_emit       (hdr_emit),
    .hdr_dest_mac   (hdr_dest_mac),
    .hdr_busy       (hdr_busy),
    .pkt_start      (pkt_start),
    .pkt_drop       (pkt_drop),
    .pkt_done       (pkt_done)
  );

  arp_cache u_cache (
    .clk      (clk),
    .rst      (rst),
    .lookup_ip(cache_lookup_ip),
    .fill     (cache_fill),
    .fill_mac (arp_resp_mac),
    .hit      (cache_hit),
    .mac      (cache_mac)
  );

  ip_hdr_assembler #(
    .CHECKSUM_PIPELINED(CHECKSUM_PIPELINED)
  ) u_hdr (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .local_mac    (local_mac),
    .load         (hdr_load),
    .fold         (hdr_fold),
    .emit         (hdr_emit),
    .dest_mac     (hdr_dest_mac),
    .out_hdr      (out_hdr),
    .out_hdr_valid(out_hdr_valid),
    .out_hdr_ready(out_hdr_ready),
    .busy         (hdr_busy)
  );

  payload_gate u_gate (
    .clk      (clk),
    .rst      (rst),
    .start    (pkt_start),
    .drop     (pkt_drop),
    .in_beat  (in_beat),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_beat (out_beat),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .done     (pkt_done)
  );

endmodule

/* verification/tb_clock_gen.sv */
// Free-running clock for the IPv4 transmit testbench.
// Instantiate once and take clk from its output, 4 ns period by default.

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 2
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

endmodule

/* verification/ip_tx_chk.sv */
// Protocol checker for the IPv4 transmit block.
// Bound to ip_tx_top from the testbench. Checks that outgoing valids and
// their data hold until accepted and that control outputs are quiet
// after reset. Failures are counted for the testbench to pick up.

`timescale 1ns/1ps

module ip_tx_chk
  import eth_pkg::*;
  import ip_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input logic        req_ready,
  input logic        in_ready,
  input eth_ip_hdr_t out_hdr,
  input logic        out_hdr_valid,
  input logic        out_hdr_ready,
  input axis_beat_t  out_beat,
  input logic        out_valid,
  input logic        out_ready,
  input logic        arp_req_valid,
  input logic        arp_req_ready,
  input ip_addr_t    arp_req_ip,
  input logic        arp_resp_ready
);

  int unsigned assert_failures = 0;

  hdr_hold: assert property (@(posedge clk) disable iff (rst)
    out_hdr_valid && !out_hdr_ready |=> out_hdr_valid && $stable(out_hdr))
    else begin
      assert_failures++;
      $error("out_hdr dropped or changed before it was accepted");
    end

  beat_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else begin
      assert_failures++;
      $error("out_beat dropped or changed before it was accepted");
    end

  arp_hold: assert property (@(posedge clk) disable iff (rst)
    arp_req_valid && !arp_req_ready |=> arp_req_valid && $stable(arp_req_ip))
    else begin
      assert_failures++;
      $error("ARP request dropped or changed before it was accepted");
    end

  // Every handshake output low once reset has been seen
  reset_quiet: assert property (@(posedge clk)
    rst |=> !(req_ready || in_ready || out_hdr_valid || out_valid ||
              arp_req_valid || arp_resp_ready))
    else begin
      assert_failures++;
      $error("control output high in the cycle after reset");
    end

endmodule

/* verification/ip_tx_tb.sv */
// Table-driven testbench for the IPv4 transmit block.
// Each table row is one packet: request, ARP answer, beat count and
// whether the cache should hit. A small ARP responder model answers
// misses, and a header model recomputes the expected checksum.

`timescale 1ns/1ps

module ip_tx_tb
  import eth_pkg::*;
  import ip_pkg::*;
();

  localparam int        NUM_ROWS       = 7;
  localparam int        TIMEOUT_CYCLES = 200;
  localparam mac_addr_t LOCAL_MAC      = 48'h02_1a_2b_3c_4d_5e;
  localparam ip_addr_t  SRC_IP         = 32'hc0a8_0001;

  typedef struct packed {
    ip_tx_req_t req;
    mac_addr_t  mac;
    logic       arp_err;
    logic       exp_hit;
    logic [7:0] n_beats;
  } row_t;

  logic        clk;
  logic        rst;
  ip_tx_req_t  req;
  logic        req_valid;
  logic        req_ready;
  axis_beat_t  in_beat;
  logic        in_valid;
  logic        in_ready;
  logic        arp_req_valid;
  logic        arp_req_ready;
  ip_addr_t    arp_req_ip;
  logic        arp_resp_valid;
  logic        arp_resp_ready;
  logic        arp_resp_error;
  mac_addr_t   arp_resp_mac;
  eth_ip_hdr_t out_hdr;
  logic        out_hdr_valid;
  logic        out_hdr_ready;
  axis_beat_t  out_beat;
  logic        out_valid;
  logic        out_ready;
  mac_addr_t   local_mac;

  row_t        rows [NUM_ROWS];
  string       row_desc [NUM_ROWS];
  axis_beat_t  sent_beats[$];
  logic        payload_sent;
  int unsigned arp_valid_cycles;

  tb_clock_gen u_clk (
    .clk(clk)
  );

  ip_tx_top #(
    .CHECKSUM_PIPELINED(0)
  ) uut (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .in_beat       (in_beat),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .arp_req_valid (arp_req_valid),
    .arp_req_ready (arp_req_ready),
    .arp_req_ip    (arp_req_ip),
    .arp_resp_valid(arp_resp_valid),
    .arp_resp_ready(arp_resp_ready),
    .arp_resp_error(arp_resp_error),
    .arp_resp_mac  (arp_resp_mac),
    .out_hdr       (out_hdr),
    .out_hdr_valid (out_hdr_valid),
    .out_hdr_ready (out_hdr_ready),
    .out_beat      (out_beat),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .local_mac     (local_mac)
  );

  bind ip_tx_top ip_tx_chk u_chk (
    .clk           (clk),
    .rst           (rst),
    .req_ready     (req_ready),
    .in_ready      (in_ready),
    .out_hdr       (out_hdr),
    .out_hdr_valid (out_hdr_valid),
    .out_hdr_ready (out_hdr_ready),
    .out_beat      (out_beat),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .arp_req_valid (arp_req_valid),
    .arp_req_ready (arp_req_ready),
    .arp_req_ip    (arp_req_ip),
    .arp_resp_ready(arp_resp_ready)
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_hdr(input string name, input eth_ip_hdr_t exp, input eth_ip_hdr_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("** Error: %s header expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("** Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_arp_ip(input string name, input ip_addr_t exp, input ip_addr_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("** Error: %s ARP ip expected %h actual %h", name, exp, act));
    end
  endtask

  // Ones'-complement sum of the ten header words, then complemented
  function automatic logic [15:0] header_checksum(input ipv4_fields_t f);
    logic [159:0] bits;
    logic [31:0]  sum;
    bits = f;
    sum  = 32'd0;
    for (int i = 0; i < 10; i++) begin
      sum = sum + {16'd0, bits[159 - 16*i -: 16]};
    end
    while (sum[31:16] != 16'd0) begin
      sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    end
    return ~sum[15:0];
  endfunction

  function automatic eth_ip_hdr_t expected_header(input row_t r);
    eth_ip_hdr_t h;
    h                 = '0;
    h.eth.dest_mac    = r.mac;
    h.eth.src_mac     = LOCAL_MAC;
    h.eth.ethertype   = 16'h0800;
    h.ip.version      = 4'd4;
    h.ip.ihl          = 4'd5;
    h.ip.dscp         = r.req.dscp;
    h.ip.ecn          = r.req.ecn;
    h.ip.total_length = r.req.length + (r.req.roce ? 16'd4 : 16'd0);
    h.ip.flags        = 3'b010;
    h.ip.ttl          = r.req.ttl;
    h.ip.protocol     = r.req.protocol;
    h.ip.source_ip    = r.req.source_ip;
    h.ip.dest_ip      = r.req.dest_ip;
    // Checksum word is still zero while summing
    h.ip.checksum     = header_checksum(h.ip);
    h.roce            = r.req.roce;
    return h;
  endfunction

  function automatic row_t make_row(input ip_addr_t dest, input logic [15:0] length,
                                    input logic roce, input mac_addr_t mac, input logic err,
                                    input logic hit, input logic [7:0] beats);
    row_t r;
    r                  = '0;
    r.req.dscp         = 6'h2e;
    r.req.ecn          = 2'b01;
    r.req.length       = length;
    r.req.ttl          = 8'd64;
    r.req.protocol     = roce ? 8'd17 : 8'd6;
    r.req.source_ip    = SRC_IP;
    r.req.dest_ip      = dest;
    r.req.roce         = roce;
    r.mac              = mac;
    r.arp_err          = err;
    r.exp_hit          = hit;
    r.n_beats          = beats;
    return r;
  endfunction

  task automatic send_request(input string name, input ip_tx_req_t r);
    int unsigned waited;
    req       = r;
    req_valid = 1'b1;
    waited    = 0;
    @(negedge clk);
    while (!req_ready) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_with_failure($sformatf("%s: request was never accepted", name));
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic send_payload(input string name);
    int unsigned waited;
    foreach (sent_beats[i]) begin
      in_beat  = sent_beats[i];
      in_valid = 1'b1;
      waited   = 0;
      @(negedge clk);
      while (!in_ready) begin
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
          stop_with_failure($sformatf("%s: payload beat %0d was never accepted", name, i));
        end
        @(negedge clk);
      end
      @(posedge clk);
      #1;
    end
    in_valid     = 1'b0;
    in_beat      = '0;
    payload_sent = 1'b1;
  endtask

  // Responder model that answers three cycles after taking the query
  task automatic answer_arp(input string name, input ip_addr_t exp_ip,
                            input mac_addr_t mac, input logic err);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (!arp_req_valid) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_with_failure($sformatf("%s: no ARP request was issued", name));
      end
      @(negedge clk);
    end
    check_arp_ip(name, exp_ip, arp_req_ip);
    @(posedge clk);
    #1;
    arp_req_ready = 1'b1;
    @(negedge clk);
    if (!arp_req_valid) begin
      stop_with_failure($sformatf("%s: ARP request withdrawn before it was taken", name));
    end
    @(posedge clk);
    #1;
    arp_req_ready = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    arp_resp_mac   = mac;
    arp_resp_error = err;
    arp_resp_valid = 1'b1;
    waited         = 0;
    @(negedge clk);
    while (!arp_resp_ready) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_with_failure($sformatf("%s: ARP response was never accepted", name));
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    arp_resp_valid = 1'b0;
    arp_resp_error = 1'b0;
    arp_resp_mac   = '0;
  endtask

  task automatic collect_header(input string name, input eth_ip_hdr_t exp);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (!(out_hdr_valid && out_hdr_ready)) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_with_failure($sformatf("%s: no header came out", name));
      end
      @(negedge clk);
    end
    check_hdr(name, exp, out_hdr);
  endtask

  task automatic collect_payload(input string name);
    int unsigned waited;
    foreach (sent_beats[i]) begin
      waited = 0;
      @(negedge clk);
      while (!(out_valid && out_ready)) begin
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
          stop_with_failure($sformatf("%s: output beat %0d never came out", name, i));
        end
        @(negedge clk);
      end
      check_beat($sformatf("%s beat %0d", name, i), sent_beats[i], out_beat);
    end
  endtask

  // Nothing may leave the block while a dropped packet drains
  task automatic watch_dropped_output(input string name);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (!payload_sent) begin
      if (out_hdr_valid || out_valid) begin
        stop_with_failure($sformatf("%s: output seen for a packet whose ARP lookup failed",
                                    name));
      end
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_with_failure($sformatf("%s: dropped payload did not drain", name));
      end
      @(negedge clk);
    end
  endtask

  task automatic run_row(input int idx);
    row_t        r;
    string       name;
    axis_beat_t  b;
    eth_ip_hdr_t exp_hdr;
    int unsigned arp_before;
    r    = rows[idx];
    name = $sformatf("row %0d (%s)", idx, row_desc[idx]);
    sent_beats.delete();
    for (int i = 0; i < int'(r.n_beats); i++) begin
      b.data = {$urandom, $urandom};
      b.last = (i == int'(r.n_beats) - 1);
      sent_beats.push_back(b);
    end
    exp_hdr      = expected_header(r);
    payload_sent = 1'b0;
    arp_before   = arp_valid_cycles;
    @(posedge clk);
    #1;
    fork
      send_request(name, r.req);
      send_payload(name);
      begin
        if (!r.exp_hit) begin
          answer_arp(name, r.req.dest_ip, r.mac, r.arp_err);
        end
      end
      begin
        if (r.arp_err) begin
          watch_dropped_output(name);
        end else begin
          collect_header(name, exp_hdr);
        end
      end
      // Header and first beat may leave in the same cycle
      begin
        if (!r.arp_err) begin
          collect_payload(name);
        end
      end
    join
    if (r.exp_hit && arp_valid_cycles != arp_before) begin
      stop_with_failure($sformatf("%s: ARP request issued on a cache hit", name));
    end
  endtask

  always @(negedge clk) begin
    if (rst) begin
      arp_valid_cycles <= 0;
    end else if (arp_req_valid) begin
      arp_valid_cycles <= arp_valid_cycles + 1;
    end
  end

  always @(negedge clk) begin
    if (uut.u_chk.assert_failures != 0) begin
      stop_with_failure("a protocol assertion in the bound checker failed");
    end
  end

  // Random back-pressure on both output channels
  initial begin
    out_ready     = 1'b0;
    out_hdr_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (rst) begin
        out_ready     = 1'b0;
        out_hdr_ready = 1'b0;
      end else begin
        out_ready     = ($urandom % 32'd4) != 32'd0;
        out_hdr_ready = ($urandom % 32'd3) != 32'd0;
      end
    end
  end

  initial begin
    void'($urandom(32'h967b725d));
    rst            = 1'b1;
    req            = '0;
    req_valid      = 1'b0;
    in_beat        = '0;
    in_valid       = 1'b0;
    arp_req_ready  = 1'b0;
    arp_resp_valid = 1'b0;
    arp_resp_error = 1'b0;
    arp_resp_mac   = '0;
    local_mac      = LOCAL_MAC;
    payload_sent   = 1'b0;

    rows[0] = make_row(32'h0a00_0005, 16'd88, 1'b0, 48'h00_11_22_33_44_55, 1'b0, 1'b0, 8'd3);
    rows[1] = make_row(32'h0a00_0005, 16'd1500, 1'b0, 48'h00_11_22_33_44_55, 1'b0, 1'b1, 8'd5);
    rows[2] = make_row(32'h0a00_0107, 16'd60, 1'b0, 48'h00_a0_c9_12_34_56, 1'b1, 1'b0, 8'd4);
    rows[3] = make_row(32'h0a00_0107, 16'd276, 1'b1, 48'h00_a0_c9_12_34_56, 1'b0, 1'b0, 8'd6);
    rows[4] = make_row(32'h0a00_0107, 16'd44, 1'b1, 48'h00_a0_c9_12_34_56, 1'b0, 1'b1, 8'd1);
    rows[5] = make_row(32'hc0a8_640a, 16'd1024, 1'b0, 48'h3c_fd_fe_01_02_03, 1'b0, 1'b0, 8'd8);
    rows[6] = make_row(32'h0a00_0005, 16'hfff0, 1'b1, 48'h00_11_22_99_88_77, 1'b0, 1'b0, 8'd2);
    row_desc[0] = "miss on first address";
    row_desc[1] = "hit on cached address";
    row_desc[2] = "ARP error drops packet";
    row_desc[3] = "RoCE miss after error";
    row_desc[4] = "RoCE hit single beat";
    row_desc[5] = "miss replaces entry";
    row_desc[6] = "RoCE miss with new MAC";

    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    repeat (5) @(posedge clk);

    if (uut.u_chk.assert_failures == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_with_failure("protocol assertions failed during the run");
    end
  end

endmodule

/* flist.f */
rtl/eth_pkg.sv
rtl/ip_pkg.sv
rtl/arp_cache.sv
rtl/ip_hdr_assembler.sv
rtl/payload_gate.sv
rtl/ip_tx_ctrl.sv
rtl/ip_tx_top.sv
verification/tb_clock_gen.sv
verification/ip_tx_chk.sv
verification/ip_tx_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the IPv4 transmit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module ip_tx_tb -f flist.f

output=$(./obj_dir/Vip_tx_tb +verilator+error+limit+10 2>&1) || true
echo "$output"

if grep -qx "STATUS: PASS" <<< "$output"; then
  exit 0
fi
exit 1
